// ==== hw/conan_pkg.sv ====
`default_nettype none

package conan_pkg;

	// System time in clock ticks.
	typedef logic [63:0] systime_t;

	// One word of the data-acquisition stream.
	typedef logic [31:0] daq_word_t;

	// Packet type, carried in the top byte of the first packet word.
	typedef logic [7:0] daq_type_t;

	localparam daq_type_t DAQT_SYSTIME_SET = 8'd32;
	localparam daq_type_t DAQT_SYSTIME_ROLLOVER = 8'd33;

	localparam int NLEDS = 8;

	// Heartbeat pattern, one bit per LED.
	typedef logic [NLEDS-1:0] led_t;

	// Systime notifier FSM.
	typedef enum logic [1:0] {
		SY_IDLE,
		SY_WAIT_GRANT,
		SY_SEND_UPPER,
		SY_SEND_LOWER
	} notifier_state_e;

	// DAQ arbiter ownership FSM.
	typedef enum logic [1:0] {
		AR_IDLE,
		AR_OWN_SYST,
		AR_OWN_MCU
	} arbiter_state_e;

endpackage

`default_nettype wire

// ==== hw/timebase.sv ====
`timescale 1ns/1ps
`default_nettype none

module timebase #(
	parameter int ROLL_BITS = 26,
	parameter int LED_TICK_BITS = 22
) (
	input wire clk,
	input wire arst_n,
	input wire conan_pkg::systime_t time_set,
	input wire time_set_en,
	output conan_pkg::systime_t systime,
	output logic rollover,
	output conan_pkg::led_t leds
);
	import conan_pkg::*;

	logic led_tick;

	// Free-running counter, overwritten by an external load.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			systime <= '0;
		end else if (time_set_en) begin
			systime <= time_set;
		end else begin
			systime <= systime + 1'b1;
		end
	end

	assign rollover = &systime[ROLL_BITS-1:0]; // High on the last tick before the field wraps.

	assign led_tick = systime[LED_TICK_BITS-1:0] == '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			leds <= led_t'(1); // LED 0 lit.
		end else if (led_tick) begin
			leds <= {leds[NLEDS-2:0], leds[NLEDS-1]};
		end
	end

endmodule

`default_nettype wire

// ==== hw/systime_notifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module systime_notifier (
	input wire clk,
	input wire arst_n,
	input wire conan_pkg::systime_t systime,
	input wire rollover,
	input wire time_set_en,
	output logic syst_daq_req,
	input wire syst_daq_grant,
	output conan_pkg::daq_word_t syst_daq_data,
	output logic syst_daq_valid,
	output logic syst_daq_end
);
	import conan_pkg::*;

	notifier_state_e state;
	logic load_seen;
	logic pending;
	logic pending_load;
	logic event_hit;
	logic start;
	daq_type_t pkt_type;
	logic [55:0] latched_time;

	// A load is taken one cycle late, so the packet carries the first tick after the loaded value.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			load_seen <= 1'b0;
		end else begin
			load_seen <= time_set_en;
		end
	end

	assign event_hit = load_seen | rollover;
	assign start = (state == SY_IDLE) && pending;

	// A new event wins over the consumption of the old one.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
			pending_load <= 1'b0;
		end else if (event_hit) begin
			pending <= 1'b1;
			pending_load <= load_seen | (pending_load & ~start); // A waiting load is not downgraded.
		end else if (start) begin
			pending <= 1'b0;
			pending_load <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= SY_IDLE;
		end else begin
			case (state)
				SY_IDLE: begin
					if (pending) begin
						state <= SY_WAIT_GRANT;
					end
				end
				SY_WAIT_GRANT: begin
					if (syst_daq_grant) begin
						state <= SY_SEND_UPPER;
					end
				end
				SY_SEND_UPPER: state <= SY_SEND_LOWER;
				SY_SEND_LOWER: state <= SY_IDLE;
				default: state <= SY_IDLE;
			endcase
		end
	end

	// Time and type are frozen when the request goes out.
	always_ff @(posedge clk) begin
		if (start) begin
			latched_time <= systime[55:0];
			pkt_type <= pending_load ? DAQT_SYSTIME_SET : DAQT_SYSTIME_ROLLOVER;
		end
	end

	assign syst_daq_req = state == SY_WAIT_GRANT;
	assign syst_daq_valid = (state == SY_SEND_UPPER) || (state == SY_SEND_LOWER);
	assign syst_daq_end = state == SY_SEND_LOWER;

	always_comb begin
		if (state == SY_SEND_UPPER) begin
			syst_daq_data = {pkt_type, latched_time[55:32]};
		end else begin
			syst_daq_data = latched_time[31:0];
		end
	end

endmodule

`default_nettype wire

// ==== hw/daq_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module daq_arbiter (
	input wire clk,
	input wire arst_n,
	input wire syst_daq_req,
	output logic syst_daq_grant,
	input wire conan_pkg::daq_word_t syst_daq_data,
	input wire syst_daq_valid,
	input wire syst_daq_end,
	input wire mcu_daq_req,
	output logic mcu_daq_grant,
	input wire conan_pkg::daq_word_t mcu_daq_data,
	input wire mcu_daq_valid,
	input wire mcu_daq_end,
	output conan_pkg::daq_word_t daq_data,
	output logic daq_valid,
	output logic daq_end
);
	import conan_pkg::*;

	arbiter_state_e state;
	daq_word_t sel_data;
	logic sel_valid;
	logic sel_end;

	// Only the owner of the stream reaches the output register.
	always_comb begin
		sel_data = syst_daq_data;
		sel_valid = 1'b0;
		sel_end = 1'b0;
		case (state)
			AR_OWN_SYST: begin
				sel_valid = syst_daq_valid;
				sel_end = syst_daq_end;
			end
			AR_OWN_MCU: begin
				sel_data = mcu_daq_data;
				sel_valid = mcu_daq_valid;
				sel_end = mcu_daq_end;
			end
			default: sel_valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= AR_IDLE;
			syst_daq_grant <= 1'b0;
			mcu_daq_grant <= 1'b0;
		end else begin
			syst_daq_grant <= 1'b0;
			mcu_daq_grant <= 1'b0;
			case (state)
				AR_IDLE: begin
					if (syst_daq_req) begin // The time base has priority.
						syst_daq_grant <= 1'b1;
						state <= AR_OWN_SYST;
					end else if (mcu_daq_req) begin
						mcu_daq_grant <= 1'b1;
						state <= AR_OWN_MCU;
					end
				end
				AR_OWN_SYST, AR_OWN_MCU: begin
					if (daq_end) begin
						state <= AR_IDLE; // Released once the last word is out.
					end
				end
				default: state <= AR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			daq_valid <= 1'b0;
			daq_end <= 1'b0;
		end else begin
			daq_valid <= sel_valid;
			daq_end <= sel_valid & sel_end;
		end
	end

	always_ff @(posedge clk) begin
		daq_data <= sel_data;
	end

endmodule

`default_nettype wire

// ==== hw/conan_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module conan_core #(
	parameter int ROLL_BITS = 26,
	parameter int LED_TICK_BITS = 22
) (
	input wire clk,
	input wire arst_n,
	input wire conan_pkg::systime_t time_set,
	input wire time_set_en,
	input wire mcu_daq_req,
	output logic mcu_daq_grant,
	input wire conan_pkg::daq_word_t mcu_daq_data,
	input wire mcu_daq_valid,
	input wire mcu_daq_end,
	output conan_pkg::daq_word_t daq_data,
	output logic daq_valid,
	output logic daq_end,
	output conan_pkg::systime_t systime,
	output conan_pkg::led_t leds
);
	import conan_pkg::*;

	logic rollover;
	logic syst_daq_req;
	logic syst_daq_grant;
	daq_word_t syst_daq_data;
	logic syst_daq_valid;
	logic syst_daq_end;

	timebase #(
		.ROLL_BITS(ROLL_BITS),
		.LED_TICK_BITS(LED_TICK_BITS)
	) timebase_i (
		.clk(clk),
		.arst_n(arst_n),
		.time_set(time_set),
		.time_set_en(time_set_en),
		.systime(systime),
		.rollover(rollover),
		.leds(leds)
	);

	systime_notifier systime_notifier_i (
		.clk(clk),
		.arst_n(arst_n),
		.systime(systime),
		.rollover(rollover),
		.time_set_en(time_set_en),
		.syst_daq_req(syst_daq_req),
		.syst_daq_grant(syst_daq_grant),
		.syst_daq_data(syst_daq_data),
		.syst_daq_valid(syst_daq_valid),
		.syst_daq_end(syst_daq_end)
	);

	daq_arbiter daq_arbiter_i (
		.clk(clk),
		.arst_n(arst_n),
		.syst_daq_req(syst_daq_req),
		.syst_daq_grant(syst_daq_grant),
		.syst_daq_data(syst_daq_data),
		.syst_daq_valid(syst_daq_valid),
		.syst_daq_end(syst_daq_end),
		.mcu_daq_req(mcu_daq_req),
		.mcu_daq_grant(mcu_daq_grant),
		.mcu_daq_data(mcu_daq_data),
		.mcu_daq_valid(mcu_daq_valid),
		.mcu_daq_end(mcu_daq_end),
		.daq_data(daq_data),
		.daq_valid(daq_valid),
		.daq_end(daq_end)
	);

endmodule

`default_nettype wire

// ==== testbench/conan_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conan_core_tb;
	import conan_pkg::*;

	localparam int ROLL_BITS = 7;
	localparam int LED_TICK_BITS = 4;
	localparam int TIMEOUT = 1000;
	localparam int SEED = 10290;

	logic clk;
	logic arst_n;
	systime_t time_set;
	logic time_set_en;
	logic mcu_daq_req;
	logic mcu_daq_grant;
	daq_word_t mcu_daq_data;
	logic mcu_daq_valid;
	logic mcu_daq_end;
	daq_word_t daq_data;
	logic daq_valid;
	logic daq_end;
	systime_t systime;
	led_t leds;

	systime_t model_sys;
	led_t model_leds;
	logic [63:0] syst_q[$]; // Expected systime packets, type byte on top of the 56-bit time.
	int syst_word_idx = 0;
	int syst_out_count = 0;
	int mcu_grant_count = 0;
	int mcu_start_syst_count = 0;
	int reset_edges = 0;
	logic first_cycle = 1'b0;
	logic in_mcu_out = 1'b0;
	logic mcu_prev_valid = 1'b0;
	logic mcu_prev_end = 1'b0;
	daq_word_t mcu_prev_data;

	conan_core #(
		.ROLL_BITS(ROLL_BITS),
		.LED_TICK_BITS(LED_TICK_BITS)
	) conan_core_i (
		.clk(clk),
		.arst_n(arst_n),
		.time_set(time_set),
		.time_set_en(time_set_en),
		.mcu_daq_req(mcu_daq_req),
		.mcu_daq_grant(mcu_daq_grant),
		.mcu_daq_data(mcu_daq_data),
		.mcu_daq_valid(mcu_daq_valid),
		.mcu_daq_end(mcu_daq_end),
		.daq_data(daq_data),
		.daq_valid(daq_valid),
		.daq_end(daq_end),
		.systime(systime),
		.leds(leds)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(
		input string name,
		input logic [63:0] expected,
		input logic [63:0] actual
	);
		$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
		abort_run();
	endtask

	task automatic report_error(input string what);
		$display("Error: %s", what);
		abort_run();
	endtask

	leds_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(leds))
		else report_error("leds is not one-hot");
	grant_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		mcu_daq_grant |=> !mcu_daq_grant)
		else report_error("mcu_daq_grant lasted longer than one cycle");
	grant_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		mcu_daq_grant |-> mcu_daq_req)
		else report_error("mcu_daq_grant came without a request");

	task automatic check_reset_outputs();
		assert (!daq_valid) else report_mismatch("reset_daq_valid", 64'd0, 64'(daq_valid));
		assert (!daq_end) else report_mismatch("reset_daq_end", 64'd0, 64'(daq_end));
		assert (!mcu_daq_grant) else report_mismatch("reset_grant", 64'd0, 64'(mcu_daq_grant));
		assert (leds == led_t'(1)) else report_mismatch("reset_leds", 64'd1, 64'(leds));
	endtask

	// MCU words are expected exactly one cycle after the input; every other word is systime.
	task automatic check_output_word();
		logic [63:0] pkt;
		if (mcu_prev_valid) begin
			if (syst_word_idx != 0) begin
				report_error("an MCU word broke into a systime packet");
			end
			if (!in_mcu_out) begin
				mcu_start_syst_count = syst_out_count;
			end
			assert (daq_valid) else report_mismatch("mcu_valid", 64'd1, 64'(daq_valid));
			assert (daq_data == mcu_prev_data)
				else report_mismatch("mcu_data", 64'(mcu_prev_data), 64'(daq_data));
			assert (daq_end == mcu_prev_end)
				else report_mismatch("mcu_end", 64'(mcu_prev_end), 64'(daq_end));
			in_mcu_out = !mcu_prev_end;
		end else if (daq_valid) begin
			if (syst_q.size() == 0) begin
				report_error("an output word arrived outside any expected packet");
			end else if (syst_word_idx == 0) begin
				pkt = syst_q[0];
				assert (daq_data == pkt[63:32])
					else report_mismatch("syst_word0", 64'(pkt[63:32]), 64'(daq_data));
				assert (!daq_end) else report_mismatch("syst_end0", 64'd0, 64'(daq_end));
				syst_word_idx = 1;
			end else begin
				pkt = syst_q.pop_front();
				if (pkt[63:56] == DAQT_SYSTIME_ROLLOVER) begin
					assert (daq_data[ROLL_BITS-1:0] == '0) else report_mismatch(
						"rollover_low_bits", 64'd0, 64'(daq_data[ROLL_BITS-1:0]));
				end
				assert (daq_data == pkt[31:0])
					else report_mismatch("syst_word1", 64'(pkt[31:0]), 64'(daq_data));
				assert (daq_end) else report_mismatch("syst_end1", 64'd1, 64'(daq_end));
				syst_word_idx = 0;
				syst_out_count++;
			end
		end else begin
			if (syst_word_idx != 0) begin
				report_error("a systime packet stopped after its first word");
			end
			assert (!daq_end) else report_mismatch("end_without_valid", 64'd0, 64'(daq_end));
		end
	endtask

	// Reference model, updated on each rising edge from the values of the cycle before it.
	always @(posedge clk) begin
		if (!arst_n) begin
			if (reset_edges > 0) begin
				check_reset_outputs(); // The first edge is where the DUT leaves x.
			end
			reset_edges++;
			model_sys = '0;
			model_leds = led_t'(1);
			first_cycle = 1'b1;
			mcu_prev_valid = 1'b0;
			in_mcu_out = 1'b0;
			syst_word_idx = 0;
		end else begin
			if (first_cycle) begin
				check_reset_outputs();
				first_cycle = 1'b0;
			end
			assert (systime == model_sys) else report_mismatch("systime", model_sys, systime);
			assert (leds == model_leds)
				else report_mismatch("heartbeat", 64'(model_leds), 64'(leds));
			check_output_word();
			if (mcu_daq_grant) begin
				mcu_grant_count++;
			end
			if (model_sys[LED_TICK_BITS-1:0] == '0) begin
				model_leds = {model_leds[NLEDS-2:0], model_leds[NLEDS-1]};
			end
			if (&model_sys[ROLL_BITS-1:0]) begin
				syst_q.push_back({DAQT_SYSTIME_ROLLOVER, model_sys[55:0] + 56'd1});
			end
			if (time_set_en) begin
				syst_q.push_back({DAQT_SYSTIME_SET, time_set[55:0] + 56'd1});
				model_sys = time_set;
			end else begin
				model_sys = model_sys + 64'd1;
			end
			mcu_prev_valid = mcu_daq_valid;
			mcu_prev_data = mcu_daq_data;
			mcu_prev_end = mcu_daq_end;
		end
	end

	task automatic wait_syst_packets(input int count);
		int target;
		int waited;
		@(negedge clk);
		target = syst_out_count + count;
		waited = 0;
		while (syst_out_count < target) begin
			if (waited == TIMEOUT) begin
				report_error("timeout while waiting for systime packets");
			end
			waited++;
			@(negedge clk);
		end
	endtask

	task automatic drain_syst_packets();
		int waited;
		waited = 0;
		@(negedge clk);
		while (syst_q.size() != 0 || syst_word_idx != 0) begin
			if (waited == TIMEOUT) begin
				report_error("timeout while waiting for the systime packets to drain");
			end
			waited++;
			@(negedge clk);
		end
	endtask

	// Loads only while the notifier is idle and the next wrap is far away.
	task automatic load_systime();
		systime_t value;
		logic [ROLL_BITS-1:0] low;
		int waited;
		value = {$urandom, $urandom};
		low = ROLL_BITS'($urandom % 96);
		value[ROLL_BITS-1:0] = low;
		waited = 0;
		@(negedge clk);
		while (syst_q.size() != 0 || syst_word_idx != 0 || systime[ROLL_BITS-1:0] >= 96) begin
			if (waited == TIMEOUT) begin
				report_error("timeout while waiting for a quiet moment to load systime");
			end
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		time_set <= value;
		time_set_en <= 1'b1;
		@(posedge clk);
		time_set_en <= 1'b0;
		@(negedge clk);
		assert (systime == value) else report_mismatch("load", value, systime);
		wait_syst_packets(1);
	endtask

	// Called right after a rising edge, where the request is driven.
	task automatic send_mcu_packet(input int nwords);
		int waited;
		int grants_before;
		mcu_daq_req <= 1'b1;
		@(negedge clk);
		grants_before = mcu_grant_count;
		waited = 0;
		while (!mcu_daq_grant) begin
			if (waited == TIMEOUT) begin
				report_error("timeout while waiting for mcu_daq_grant");
			end
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		mcu_daq_req <= 1'b0;
		for (int i = 0; i < nwords; i++) begin
			mcu_daq_data <= $urandom;
			mcu_daq_valid <= 1'b1;
			mcu_daq_end <= (i == nwords - 1);
			@(posedge clk);
		end
		mcu_daq_valid <= 1'b0;
		mcu_daq_end <= 1'b0;
		repeat (2) @(negedge clk);
		assert (mcu_grant_count == grants_before + 1)
			else report_mismatch("mcu_grants", 64'(grants_before + 1), 64'(mcu_grant_count));
	endtask

	// MCU request lands in the same cycle as the notifier's rollover request.
	task automatic contend_with_rollover();
		int waited;
		int syst_before;
		waited = 0;
		@(negedge clk);
		while (systime[ROLL_BITS-1:0] != '0 || syst_q.size() != 1) begin
			if (waited == TIMEOUT) begin
				report_error("timeout while waiting for a pending rollover packet");
			end
			waited++;
			@(negedge clk);
		end
		syst_before = syst_out_count;
		@(posedge clk);
		send_mcu_packet(1 + int'($urandom % 5));
		assert (mcu_start_syst_count == syst_before + 1) else report_mismatch(
			"contention_order", 64'(syst_before + 1), 64'(mcu_start_syst_count));
	endtask

	initial begin
		int nwords;
		int idle;
		void'($urandom(SEED));
		arst_n = 1'b0;
		time_set = '0;
		time_set_en = 1'b0;
		mcu_daq_req = 1'b0;
		mcu_daq_data = '0;
		mcu_daq_valid = 1'b0;
		mcu_daq_end = 1'b0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		wait_syst_packets(3);
		for (int i = 0; i < 4; i++) begin
			load_systime();
		end
		wait_syst_packets(1);
		for (int i = 0; i < 8; i++) begin
			nwords = 1 + int'($urandom % 5);
			@(posedge clk);
			send_mcu_packet(nwords);
			idle = int'($urandom % 4);
			repeat (idle) @(posedge clk);
		end
		contend_with_rollover();
		contend_with_rollover();
		drain_syst_packets();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/conan_pkg.sv
hw/timebase.sv
hw/systime_notifier.sv
hw/daq_arbiter.sv
hw/conan_core.sv
testbench/conan_core_tb.sv

// ==== Bender.yml ====
package:
  name: conan_core

sources:
  - files:
      - hw/conan_pkg.sv
      - hw/timebase.sv
      - hw/systime_notifier.sv
      - hw/daq_arbiter.sv
      - hw/conan_core.sv
  - target: test
    files:
      - testbench/conan_core_tb.sv
